/* common/fp_misc_config.svh */
// Format and sizing constants shared by the single-precision misc FP unit
`ifndef FP_MISC_CONFIG_SVH
`define FP_MISC_CONFIG_SVH

// Single-precision layout
`define FP_WIDTH 32
`define FP_EXP_W 8
`define FP_MAN_W 23

// Integer source width for conversions and moves
`define INT_WIDTH 32

// Instruction id carried to write-back
`define ID_WIDTH 3

// RISC-V canonical quiet NaN
`define FP_CANON_NAN 32'h7fc0_0000

`endif

/* common/fp_misc_pkg.sv */
// Types for the misc FP unit: operations, rounding modes, flags, request and result
`include "fp_misc_config.svh"

package fp_misc_pkg;

    // Operation select, decoded by the unit top
    typedef enum logic [2:0] {
        FSGNJ     = 3'd0,
        FSGNJN    = 3'd1,
        FSGNJX    = 3'd2,
        FMIN      = 3'd3,
        FMAX      = 3'd4,
        FCVT_S_W  = 3'd5,
        FCVT_S_WU = 3'd6,
        FMV_W_X   = 3'd7
    } fp_op_t;

    // RISC-V static rounding mode encodings
    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } fp_rm_t;

    // fflags, same bit order as the CSR
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fp_flags_t;

    typedef struct packed {
        fp_op_t                 op;
        fp_rm_t                 rm;
        logic [`ID_WIDTH-1:0]   id;
        logic [`FP_WIDTH-1:0]   rs1;
        logic [`FP_WIDTH-1:0]   rs2;
        logic [`INT_WIDTH-1:0]  int_src;
    } fp_misc_req_t;

    typedef struct packed {
        logic [`FP_WIDTH-1:0]   rd;
        fp_flags_t              fflags;
        logic [`ID_WIDTH-1:0]   id;
    } fp_misc_wb_t;

    // One operator's output before the write-back register
    typedef struct packed {
        logic [`FP_WIDTH-1:0]   value;
        fp_flags_t              fflags;
    } fp_result_t;

endpackage

/* fp_misc/fp_sign_inj.sv */
// Sign injection for FSGNJ, FSGNJN and FSGNJX, purely combinational
`timescale 1ns/10ps
`include "fp_misc_config.svh"

module fp_sign_inj (
    input  fp_misc_pkg::fp_op_t      op,
    input  logic [`FP_WIDTH-1:0]     rs1,
    input  logic [`FP_WIDTH-1:0]     rs2,
    output fp_misc_pkg::fp_result_t  result
);
    import fp_misc_pkg::*;

    logic sign_rs1;
    logic sign_rs2;
    logic sign_out;

    assign sign_rs1 = rs1[`FP_WIDTH-1];
    assign sign_rs2 = rs2[`FP_WIDTH-1];

    // Pick the injected sign
    always_comb begin
        case (op)
            FSGNJN:  sign_out = ~sign_rs2;
            FSGNJX:  sign_out = sign_rs1 ^ sign_rs2;
            // FSGNJ and anything else routed here
            default: sign_out = sign_rs2;
        endcase
    end

    // Magnitude of rs1 untouched, NaN payloads included
    assign result.value = {sign_out, rs1[`FP_WIDTH-2:0]};

    // Sign injection never signals
    assign result.fflags = '0;

endmodule

/* fp_misc/fp_minmax.sv */
// IEEE 754-2019 minimumNumber/maximumNumber for FMIN and FMAX
`timescale 1ns/10ps
`include "fp_misc_config.svh"

module fp_minmax (
    input  fp_misc_pkg::fp_op_t      op,
    input  logic [`FP_WIDTH-1:0]     rs1,
    input  logic [`FP_WIDTH-1:0]     rs2,
    output fp_misc_pkg::fp_result_t  result
);
    import fp_misc_pkg::*;

    logic a_nan;
    logic b_nan;
    logic a_snan;
    logic b_snan;
    logic a_lt_b;
    logic is_max;

    ////////////////////////////////////////
    // Operand classification
    // Exponent all ones with nonzero fraction
    assign a_nan = (&rs1[`FP_WIDTH-2 -: `FP_EXP_W]) & (|rs1[`FP_MAN_W-1:0]);
    assign b_nan = (&rs2[`FP_WIDTH-2 -: `FP_EXP_W]) & (|rs2[`FP_MAN_W-1:0]);
    // Quiet bit clear means signaling
    assign a_snan = a_nan & ~rs1[`FP_MAN_W-1];
    assign b_snan = b_nan & ~rs2[`FP_MAN_W-1];

    ////////////////////////////////////////
    // Sign-magnitude ordering
    // Differing signs: negative side is smaller, so -0 < +0 falls out here
    always_comb begin
        if (rs1[`FP_WIDTH-1] != rs2[`FP_WIDTH-1])
            a_lt_b = rs1[`FP_WIDTH-1];
        else if (rs1[`FP_WIDTH-1])
            a_lt_b = rs1[`FP_WIDTH-2:0] > rs2[`FP_WIDTH-2:0];
        else
            a_lt_b = rs1[`FP_WIDTH-2:0] < rs2[`FP_WIDTH-2:0];
    end

    assign is_max = (op == FMAX);

    ////////////////////////////////////////
    // Result select
    always_comb begin
        result.fflags    = '0;
        result.fflags.nv = a_snan | b_snan;
        if (a_nan && b_nan)
            result.value = `FP_CANON_NAN;
        else if (a_nan)
            result.value = rs2;
        else if (b_nan)
            result.value = rs1;
        else if (is_max)
            result.value = a_lt_b ? rs2 : rs1;
        else
            result.value = a_lt_b ? rs1 : rs2;
    end

    // Any NaN leaving the block must already be canonical
    always_comb begin
        assert final (!((&result.value[`FP_WIDTH-2 -: `FP_EXP_W]) &&
                        (|result.value[`FP_MAN_W-1:0])) ||
                      result.value == `FP_CANON_NAN)
            else $error("fp_minmax: non-canonical NaN %h", result.value);
    end

endmodule

/* fp_misc/fp_i2f.sv */
// Signed/unsigned 32-bit integer to single-precision conversion with rounding
`timescale 1ns/10ps
`include "fp_misc_config.svh"

module fp_i2f (
    input  logic                     is_unsigned,
    input  fp_misc_pkg::fp_rm_t      rm,
    input  logic [`INT_WIDTH-1:0]    int_src,
    output fp_misc_pkg::fp_result_t  result
);
    import fp_misc_pkg::*;

    // Exponent bias, 127 for single
    localparam int BIAS = (1 << (`FP_EXP_W - 1)) - 1;
    // Guard bit position once the leading one sits at the MSB
    localparam int GUARD_POS = `INT_WIDTH - `FP_MAN_W - 2;

    logic                    sign;
    logic [`INT_WIDTH-1:0]   mag;
    logic [5:0]              lz;
    logic [`INT_WIDTH-1:0]   norm;
    logic [`FP_MAN_W:0]      keep;
    logic                    guard;
    logic                    sticky;
    logic                    round_up;
    logic [`FP_MAN_W+1:0]    sum;
    logic [`FP_EXP_W-1:0]    exp_base;
    logic [`FP_EXP_W-1:0]    exp_out;

    // Leading zero count, 32 for a zero word
    function automatic logic [5:0] count_lz(input logic [`INT_WIDTH-1:0] x);
        logic [5:0] n;
        n = 6'(`INT_WIDTH);
        // Scan up so the highest set bit wins
        for (int i = 0; i < `INT_WIDTH; i++) begin
            if (x[i])
                n = 6'(`INT_WIDTH - 1 - i);
        end
        return n;
    endfunction

    ////////////////////////////////////////
    // Sign and magnitude
    // Negating INT_MIN gives 0x80000000, read as unsigned it is right
    assign sign = ~is_unsigned & int_src[`INT_WIDTH-1];
    assign mag  = sign ? (~int_src + 1'b1) : int_src;

    // Normalize so the hidden one lands at the MSB
    assign lz   = count_lz(mag);
    assign norm = mag << lz;

    // 24 kept bits, guard below, sticky for the rest
    assign keep   = norm[`INT_WIDTH-1 -: `FP_MAN_W+1];
    assign guard  = norm[GUARD_POS];
    assign sticky = |norm[GUARD_POS-1:0];

    ////////////////////////////////////////
    // Rounding
    always_comb begin
        case (rm)
            RNE:     round_up = guard & (sticky | keep[0]);
            RTZ:     round_up = 1'b0;
            RDN:     round_up = sign & (guard | sticky);
            RUP:     round_up = ~sign & (guard | sticky);
            RMM:     round_up = guard;
            default: round_up = 1'b0;
        endcase
    end

    // Carry out of the significand bumps the exponent, fraction goes to zero
    assign sum      = {1'b0, keep} + (`FP_MAN_W+2)'(round_up);
    assign exp_base = `FP_EXP_W'(BIAS + `INT_WIDTH - 1) - `FP_EXP_W'(lz);
    assign exp_out  = exp_base + `FP_EXP_W'(sum[`FP_MAN_W+1]);

    always_comb begin
        result.fflags    = '0;
        result.fflags.nx = guard | sticky;
        // Zero in, +0 out
        if (mag == '0)
            result.value = '0;
        else if (sum[`FP_MAN_W+1])
            result.value = {sign, exp_out, `FP_MAN_W'(0)};
        else
            result.value = {sign, exp_out, sum[`FP_MAN_W-1:0]};
    end

endmodule

/* fp_misc/fp_misc_unit.sv */
// Misc FP execution unit sharing one registered FP write-back port
`timescale 1ns/10ps
`include "fp_misc_config.svh"

module fp_misc_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  fp_misc_pkg::fp_misc_req_t  issue_req,
    input  logic                       issue_valid,
    output logic                       issue_ready,
    output fp_misc_pkg::fp_misc_wb_t   wb,
    output logic                       wb_done,
    input  logic                       wb_ack
);
    import fp_misc_pkg::*;

    fp_result_t sign_res;
    fp_result_t minmax_res;
    fp_result_t i2f_res;
    fp_result_t mv_res;
    fp_result_t sel_res;
    logic       advance;

    ////////////////////////////////////////
    // Operators, all zero latency
    fp_sign_inj i_fp_sign_inj (
        .op     (issue_req.op),
        .rs1    (issue_req.rs1),
        .rs2    (issue_req.rs2),
        .result (sign_res)
    );

    fp_minmax i_fp_minmax (
        .op     (issue_req.op),
        .rs1    (issue_req.rs1),
        .rs2    (issue_req.rs2),
        .result (minmax_res)
    );

    fp_i2f i_fp_i2f (
        .is_unsigned (issue_req.op == FCVT_S_WU),
        .rm          (issue_req.rm),
        .int_src     (issue_req.int_src),
        .result      (i2f_res)
    );

    // FMV.W.X is a raw bit move
    assign mv_res.value  = issue_req.int_src;
    assign mv_res.fflags = '0;

    ////////////////////////////////////////
    // Decode and select
    always_comb begin
        case (issue_req.op)
            FSGNJ, FSGNJN, FSGNJX: sel_res = sign_res;
            FMIN, FMAX:            sel_res = minmax_res;
            FCVT_S_W, FCVT_S_WU:   sel_res = i2f_res;
            default:               sel_res = mv_res;
        endcase
    end

    ////////////////////////////////////////
    // Write-back register and handshake
    // Slot is free once drained or being acked this cycle
    assign advance     = wb_ack | ~wb_done;
    assign issue_ready = advance;

    always_ff @(posedge clk) begin
        if (!rst_n)
            wb_done <= 1'b0;
        else if (advance)
            wb_done <= issue_valid;
    end

    // Payload only loads on an accepted request, id rides along
    always_ff @(posedge clk) begin
        if (advance && issue_valid) begin
            wb.rd     <= sel_res.value;
            wb.fflags <= sel_res.fflags;
            wb.id     <= issue_req.id;
        end
    end

    // Held result must not move until acked
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_done && !wb_ack |=> wb_done && $stable(wb));

    // A request refused while not ready stays on offer, unchanged
    assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_req));

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset source, 40 ns period with a 2-cycle synchronous reset
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset spans two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

/* testbench/fp_misc_tb.sv */
// Testbench for the misc FP unit, random requests checked against a reference model
`timescale 1ns/10ps
`include "fp_misc_config.svh"

module fp_misc_tb;
    import fp_misc_pkg::*;

    localparam int KIND_SGN = 0;
    localparam int KIND_MM = 1;
    localparam int KIND_CVT = 2;
    localparam int KIND_MV = 3;
    localparam int KIND_MIX = 4;
    localparam int N_RST = 20;
    localparam int N_SGN = 300;
    localparam int N_MM = 300;
    localparam int N_CVT = 400;
    localparam int N_MV = 100;
    localparam int N_HS = 200;
    localparam int CYCLE_LIMIT = 4 * (N_RST + N_SGN + N_MM + N_CVT + N_MV + N_HS) + 100;

    logic clk;
    logic rst_n;
    fp_misc_req_t issue_req;
    logic issue_valid;
    logic issue_ready;
    fp_misc_wb_t wb;
    logic wb_done;
    logic wb_ack;

    logic [31:0] rng_state = 32'h8b95_601b;
    logic [`ID_WIDTH-1:0] next_id = '0;
    fp_misc_wb_t exp_q[$];
    logic exp_done = 1'b0;
    logic held = 1'b0;
    fp_misc_wb_t held_wb;
    int error_count = 0;
    int result_count = 0;
    int cycles;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .rst_n(rst_n));

    fp_misc_unit i_fp_misc_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_req   (issue_req),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .wb          (wb),
        .wb_done     (wb_done),
        .wb_ack      (wb_ack)
    );

    ////////////////////////////////////////
    // Stimulus
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic chance(input int pct);
        return int'(next_rand() % 100) < pct;
    endfunction

    // Mostly special values: zeros, infinities, qNaN, sNaN
    function automatic logic [31:0] rand_fp();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return {r[31], 31'h0};
            3'd1: return {r[31], 8'hff, 23'h0};
            3'd2: return {r[31], 8'hff, 1'b1, r[25:4]};
            3'd3: return {r[31], 8'hff, 1'b0, r[25:4] | 22'h1};
            3'd4: return {r[31], 8'h7f, r[25:3]};
            default: return next_rand();
        endcase
    endfunction

    // Edge integers, powers of two, small signed values
    function automatic logic [31:0] rand_int();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return 32'h0;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'hffff_ffff;
            3'd3: return 32'h1 << r[8:4];
            3'd4: return {{16{r[31]}}, r[23:8]};
            default: return next_rand();
        endcase
    endfunction

    function automatic fp_misc_req_t make_req(input int kind);
        fp_misc_req_t r;
        int k;
        logic [31:0] sel;
        k = (kind == KIND_MIX) ? int'(next_rand() % 4) : kind;
        sel = next_rand();
        r.rs1 = rand_fp();
        // Same magnitude, flipped sign now and then
        r.rs2 = (sel[7:5] == 3'd0) ? {~r.rs1[31], r.rs1[30:0]} : rand_fp();
        r.int_src = rand_int();
        r.id = next_id;
        next_id = next_id + 1'b1;
        case (int'(sel % 5))
            0: r.rm = RNE;
            1: r.rm = RTZ;
            2: r.rm = RDN;
            3: r.rm = RUP;
            default: r.rm = RMM;
        endcase
        case (k)
            KIND_SGN: r.op = sel[20] ? FSGNJX : (sel[21] ? FSGNJN : FSGNJ);
            KIND_MM: r.op = sel[21] ? FMAX : FMIN;
            KIND_CVT: r.op = sel[21] ? FCVT_S_WU : FCVT_S_W;
            default: r.op = FMV_W_X;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////
    // Reference model
    function automatic logic is_nan(input logic [31:0] x);
        return x[30:23] == 8'hff && x[22:0] != 23'h0;
    endfunction

    function automatic fp_result_t model_minmax(input logic is_max, input logic [31:0] a,
                                                input logic [31:0] b);
        fp_result_t res;
        logic [31:0] ka;
        logic [31:0] kb;
        // Unsigned keys in float order, -0 lands just below +0
        ka = a[31] ? ~a : (a | 32'h8000_0000);
        kb = b[31] ? ~b : (b | 32'h8000_0000);
        res = '0;
        res.fflags.nv = (is_nan(a) && !a[22]) || (is_nan(b) && !b[22]);
        if (is_nan(a) && is_nan(b))
            res.value = `FP_CANON_NAN;
        else if (is_nan(a))
            res.value = b;
        else if (is_nan(b))
            res.value = a;
        else
            res.value = ((ka >= kb) == is_max) ? a : b;
        return res;
    endfunction

    function automatic fp_result_t model_i2f(input logic is_uns, input fp_rm_t rm,
                                             input logic [31:0] x);
        fp_result_t res;
        logic neg;
        logic inc;
        logic [63:0] mag;
        logic [63:0] kept;
        logic [63:0] rem;
        logic [63:0] half;
        int msb;
        int biased_exp;
        res = '0;
        neg = !is_uns && x[31];
        mag = neg ? (64'h1_0000_0000 - {32'h0, x}) : {32'h0, x};
        if (mag == 64'h0)
            return res;
        msb = 0;
        for (int i = 0; i < 64; i++)
            if (mag[i])
                msb = i;
        rem = 64'h0;
        inc = 1'b0;
        if (msb <= 23) begin
            kept = mag << (23 - msb);
        end else begin
            kept = mag >> (msb - 23);
            rem = mag & ((64'h1 << (msb - 23)) - 64'h1);
            half = 64'h1 << (msb - 24);
            case (rm)
                RNE: inc = (rem > half) || (rem == half && kept[0]);
                RTZ: inc = 1'b0;
                RDN: inc = neg && rem != 64'h0;
                RUP: inc = !neg && rem != 64'h0;
                default: inc = rem >= half;
            endcase
        end
        biased_exp = 127 + msb;
        kept = kept + {63'h0, inc};
        // Rounded past 24 bits, renormalize
        if (kept[24]) begin
            kept = kept >> 1;
            biased_exp++;
        end
        res.value = {neg, 8'(biased_exp), kept[22:0]};
        res.fflags.nx = rem != 64'h0;
        return res;
    endfunction

    function automatic fp_misc_wb_t model_wb(input fp_misc_req_t r);
        fp_misc_wb_t w;
        fp_result_t res;
        res = '0;
        case (r.op)
            FSGNJ: res.value = {r.rs2[31], r.rs1[30:0]};
            FSGNJN: res.value = {~r.rs2[31], r.rs1[30:0]};
            FSGNJX: res.value = {r.rs1[31] ^ r.rs2[31], r.rs1[30:0]};
            FMIN, FMAX: res = model_minmax(r.op == FMAX, r.rs1, r.rs2);
            FCVT_S_W: res = model_i2f(1'b0, r.rm, r.int_src);
            FCVT_S_WU: res = model_i2f(1'b1, r.rm, r.int_src);
            default: res.value = r.int_src;
        endcase
        w.rd = res.value;
        w.fflags = res.fflags;
        w.id = r.id;
        return w;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    task automatic check_flags(input fp_flags_t got, input fp_flags_t want, input string what);
        if (got !== want) begin
            $display("CHECK FAILED @%0t: %s fflags %b, expected %b", $time, what, got, want);
            error_count++;
        end
    endtask

    task automatic check_wb(input fp_misc_wb_t got, input fp_misc_wb_t want, input string what);
        if (got.rd !== want.rd || got.id !== want.id) begin
            $display("CHECK FAILED @%0t: %s rd %h id %0d, expected rd %h id %0d",
                     $time, what, got.rd, got.id, want.rd, want.id);
            error_count++;
        end
        check_flags(got.fflags, want.fflags, what);
    endtask

    // Issue count requests with random gaps and random write-back stalls, then drain
    task automatic run_test(input string name, input int kind, input int count,
                            input int valid_pct, input int ack_pct);
        int issued;
        int errs_before;
        int results_before;
        logic pending;
        logic accept;
        logic consume;
        fp_misc_wb_t seen;
        fp_misc_wb_t want;
        issued = 0;
        pending = 1'b0;
        errs_before = error_count;
        results_before = result_count;
        while (issued < count || pending || exp_done) begin
            @(negedge clk);
            seen = wb;
            // Exactly one cycle from accept to done
            if (wb_done !== exp_done) begin
                $display("CHECK FAILED @%0t: wb_done %b, expected %b", $time, wb_done, exp_done);
                error_count++;
            end
            if (held && wb_done && seen !== held_wb) begin
                $display("CHECK FAILED @%0t: wb changed while held", $time);
                error_count++;
            end
            if (!pending && issued < count && chance(valid_pct)) begin
                issue_req = make_req(kind);
                pending = 1'b1;
            end
            issue_valid = pending;
            wb_ack = chance(ack_pct);
            #1;
            if (issue_ready !== (wb_ack || !wb_done)) begin
                $display("CHECK FAILED @%0t: issue_ready %b with wb_done %b wb_ack %b",
                         $time, issue_ready, wb_done, wb_ack);
                error_count++;
            end
            accept = issue_valid && issue_ready;
            consume = wb_done && wb_ack;
            if (consume) begin
                result_count++;
                if (exp_q.size() == 0) begin
                    $display("Write-back arrived with no request outstanding at %0t", $time);
                    error_count++;
                end else begin
                    want = exp_q.pop_front();
                    check_wb(seen, want, name);
                end
            end
            if (accept) begin
                exp_q.push_back(model_wb(issue_req));
                issued++;
                pending = 1'b0;
            end
            held = wb_done && !wb_ack;
            held_wb = seen;
            exp_done = accept || (exp_done && !consume);
        end
        if (result_count - results_before != count) begin
            $display("Test %s got %0d results for %0d requests", name,
                     result_count - results_before, count);
            error_count++;
        end
        $display("test %-14s %0d results, %0d errors", name, count, error_count - errs_before);
    endtask

    ////////////////////////////////////////
    // Run limit
    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        // Request offered and acked all through reset, reset has to drop it
        issue_req = '0;
        issue_valid = 1'b1;
        wb_ack = 1'b1;
        wait (rst_n === 1'b1);
        issue_valid = 1'b0;
        wb_ack = 1'b0;
        #1;
        // Empty and ready straight out of reset
        if (wb_done !== 1'b0 || issue_ready !== 1'b1) begin
            $display("CHECK FAILED @%0t: after reset wb_done %b issue_ready %b",
                     $time, wb_done, issue_ready);
            error_count++;
        end
        $display("test %-14s %0d errors", "reset_state", error_count);
        run_test("reset_latency", KIND_MIX, N_RST, 100, 100);
        run_test("sign_inj", KIND_SGN, N_SGN, 80, 75);
        run_test("minmax", KIND_MM, N_MM, 80, 75);
        run_test("fcvt", KIND_CVT, N_CVT, 80, 75);
        run_test("fmv", KIND_MV, N_MV, 80, 75);
        run_test("handshake", KIND_MIX, N_HS, 80, 40);
        $display("Summary: %0d results checked, %0d errors, %0d cycles",
                 result_count, error_count, cycles);
        if (error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end
endmodule

/* files.f */
+incdir+common
common/fp_misc_pkg.sv
fp_misc/fp_sign_inj.sv
fp_misc/fp_minmax.sv
fp_misc/fp_i2f.sv
fp_misc/fp_misc_unit.sv
testbench/tb_clock_gen.sv
testbench/fp_misc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the misc FP unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module fp_misc_tb --Mdir obj_dir -o fp_misc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fp_misc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** FAILED ***" "$LOG"; then
    exit 1
fi
exit 0
